/* verilog.f */
+incdir+test
logic/skinny_cu_pkg.sv
logic/round_constant_lfsr.sv
logic/block_formatter.sv
logic/tag_checker.sv
logic/aead_sequencer.sv
logic/skinny_aead_cu.sv
test/tb_skinny_aead_cu.sv

/* run_sim.sh */
#!/bin/sh
# build and run with Verilator, verdict taken from the log
verilator --binary --timing --assert -f verilog.f --top-module tb_skinny_aead_cu \
	-o sim_tb > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0

/* test/cu_model.svh */
`ifndef CU_MODEL_SVH
`define CU_MODEL_SVH

skinny_cu_pkg::cu_state_t m_state;
skinny_cu_pkg::beat_t     m_beat;
skinny_cu_pkg::rc_t       m_rc;
skinny_cu_pkg::len_t      m_ad_len;
skinny_cu_pkg::len_t      m_msg_len;
skinny_cu_pkg::domain_t   m_domain;
logic                     m_dec;
logic                     m_acc; // tag words seen so far were all zero

skinny_cu_pkg::word_t     exp_pdi;
skinny_cu_pkg::cu_ctrl_t  exp_ctrl;
logic                     exp_ready;
logic                     exp_pvalid;
logic                     exp_fail;

function automatic skinny_cu_pkg::domain_t tail_domain(input logic ad, input logic valid,
		input logic lst, input skinny_cu_pkg::len_t len);
	if (valid && lst && len == '0)
		return ad ? skinny_cu_pkg::dom_ad_final : skinny_cu_pkg::dom_msg_final;
	if (valid && !lst)
		return ad ? skinny_cu_pkg::dom_ad_normal : skinny_cu_pkg::dom_msg_normal;
	return ad ? skinny_cu_pkg::dom_ad_padded : skinny_cu_pkg::dom_msg_padded; // padded or empty
endfunction

function automatic skinny_cu_pkg::word_t tail_word(input logic valid, input logic lst,
		input skinny_cu_pkg::len_t len, input skinny_cu_pkg::word_t data);
	if (!valid)
		return {28'd0, len};
	if (lst && len != '0)
		return {data[31:4], len};
	return data;
endfunction

// bit order srst senc sse xrst xenc xse load_l decrypt
function automatic skinny_cu_pkg::cu_ctrl_t ctrl_pattern(input skinny_cu_pkg::cu_state_t s,
		input logic end_beat, input logic dec);
	case (s)
		skinny_cu_pkg::st_idle: return skinny_cu_pkg::cu_ctrl_t'(8'b1110_0000);
		skinny_cu_pkg::st_store_key: return skinny_cu_pkg::cu_ctrl_t'(8'b0001_1100);
		skinny_cu_pkg::st_store_nonce,
		skinny_cu_pkg::st_output_tag: return skinny_cu_pkg::cu_ctrl_t'(8'b0110_0000);
		skinny_cu_pkg::st_encrypt_nonce,
		skinny_cu_pkg::st_encrypt_ad,
		skinny_cu_pkg::st_encrypt_msg: return skinny_cu_pkg::cu_ctrl_t'(8'b0100_1000);
		skinny_cu_pkg::st_store_l: return skinny_cu_pkg::cu_ctrl_t'({end_beat, 7'b111_1110});
		skinny_cu_pkg::st_store_ad:
			return skinny_cu_pkg::cu_ctrl_t'({3'b011, 1'b0, end_beat, end_beat, 2'b00});
		skinny_cu_pkg::st_store_msg:
			return skinny_cu_pkg::cu_ctrl_t'({3'b011, 1'b0, end_beat, end_beat, 1'b0, dec});
		default: return skinny_cu_pkg::cu_ctrl_t'(8'h00);
	endcase
endfunction

task automatic model_reset();
	m_state   = skinny_cu_pkg::st_idle;
	m_beat    = '0;
	m_rc      = '0;
	m_ad_len  = '0;
	m_msg_len = '0;
	m_domain  = '0;
	m_dec     = 1'b0;
	m_acc     = 1'b1;
endtask

task automatic model_expect(input logic valid, input logic lst,
		input skinny_cu_pkg::word_t data, input skinny_cu_pkg::word_t pdo_in);
	logic ad;
	logic msg;
	logic done;
	logic end_beat;
	ad       = (m_state == skinny_cu_pkg::st_store_ad);
	msg      = (m_state == skinny_cu_pkg::st_store_msg);
	done     = (m_rc == skinny_cu_pkg::final_const_default);
	end_beat = (m_beat == 2'd3);
	exp_pdi  = valid ? data : '0;
	if ((ad || msg) && end_beat)
		exp_pdi = tail_word(valid, lst, ad ? m_ad_len : m_msg_len, data);
	if (m_state == skinny_cu_pkg::st_store_l || m_state == skinny_cu_pkg::st_output_tag)
		exp_pdi = '0;
	exp_ctrl  = ctrl_pattern(m_state, end_beat, m_dec);
	exp_ready = (m_state == skinny_cu_pkg::st_idle) || (m_state == skinny_cu_pkg::st_store_nonce)
		|| (m_state == skinny_cu_pkg::st_encrypt_nonce && done) || ((ad || msg) && valid)
		|| (m_state == skinny_cu_pkg::st_encrypt_ad && done && !valid);
	exp_pvalid = (msg && valid) || (m_state == skinny_cu_pkg::st_output_tag)
		|| (m_state == skinny_cu_pkg::st_verify_tag && end_beat);
	exp_fail = (m_state == skinny_cu_pkg::st_verify_tag) && end_beat
		&& !(m_acc && pdo_in == '0);
endtask

task automatic model_advance(input logic valid, input logic lst,
		input skinny_cu_pkg::word_t data, input skinny_cu_pkg::word_t pdo_in);
	skinny_cu_pkg::cu_state_t nxt;
	logic end_beat;
	logic done;
	logic four;
	nxt      = m_state;
	end_beat = (m_beat == 2'd3);
	done     = (m_rc == skinny_cu_pkg::final_const_default);
	case (m_state)
		skinny_cu_pkg::st_idle: begin
			m_domain = '0;
			if (valid) begin
				m_msg_len = data[3:0];
				m_ad_len  = data[7:4];
				if (data[31:28] == skinny_cu_pkg::op_ldkey) nxt = skinny_cu_pkg::st_store_key;
				if (data[31:28] == skinny_cu_pkg::op_enc
						|| data[31:28] == skinny_cu_pkg::op_dec) begin
					nxt   = skinny_cu_pkg::st_store_nonce;
					m_dec = (data[31:28] == skinny_cu_pkg::op_dec);
				end
			end
		end
		skinny_cu_pkg::st_store_key, skinny_cu_pkg::st_output_tag, skinny_cu_pkg::st_verify_tag:
			if (end_beat) nxt = skinny_cu_pkg::st_idle;
		skinny_cu_pkg::st_store_nonce: if (end_beat) begin
			nxt  = skinny_cu_pkg::st_encrypt_nonce;
			m_rc = '0;
		end
		skinny_cu_pkg::st_store_l: if (end_beat) nxt = skinny_cu_pkg::st_store_ad;
		skinny_cu_pkg::st_store_ad, skinny_cu_pkg::st_store_msg: if (end_beat) begin
			m_domain = tail_domain(m_state == skinny_cu_pkg::st_store_ad, valid, lst,
				(m_state == skinny_cu_pkg::st_store_ad) ? m_ad_len : m_msg_len);
			m_rc = '0;
			nxt  = (m_state == skinny_cu_pkg::st_store_ad) ?
				skinny_cu_pkg::st_encrypt_ad : skinny_cu_pkg::st_encrypt_msg;
		end
		default: begin // the three round phases
			m_rc = {m_rc[4:0], ~(m_rc[5] ^ m_rc[4])};
			if (done) begin
				if (m_state == skinny_cu_pkg::st_encrypt_nonce) nxt = skinny_cu_pkg::st_store_l;
				else if (m_state == skinny_cu_pkg::st_encrypt_ad)
					nxt = valid ? skinny_cu_pkg::st_store_ad : skinny_cu_pkg::st_store_msg;
				else if (valid) nxt = skinny_cu_pkg::st_store_msg;
				else nxt = m_dec ? skinny_cu_pkg::st_verify_tag : skinny_cu_pkg::st_output_tag;
			end
		end
	endcase
	m_acc = (m_state == skinny_cu_pkg::st_verify_tag) ? (m_acc && pdo_in == '0) : 1'b1;
	four  = (m_state != skinny_cu_pkg::st_idle) && (m_state != skinny_cu_pkg::st_encrypt_nonce)
		&& (m_state != skinny_cu_pkg::st_encrypt_ad) && (m_state != skinny_cu_pkg::st_encrypt_msg);
	m_beat  = four ? m_beat + 2'd1 : 2'd0;
	m_state = nxt;
endtask

`endif

/* test/tb_skinny_aead_cu.sv */
`timescale 1ns/1ps

module tb_skinny_aead_cu;

	logic                    clk;
	logic                    rst;
	skinny_cu_pkg::word_t    pdi_data;
	logic                    pdi_valid;
	logic                    last;
	skinny_cu_pkg::word_t    pdo;
	skinny_cu_pkg::word_t    pdi;
	logic                    pdi_ready;
	logic                    pdo_valid;
	skinny_cu_pkg::cu_ctrl_t ctrl;
	skinny_cu_pkg::domain_t  domain;
	logic                    fail;

	int unsigned issued;
	int unsigned cycles;
	int unsigned ad_left; // extra blocks still to send
	int unsigned msg_left;
	logic        tag_zero; // whole tag reads back as zero
	logic        running;

	`include "cu_model.svh"

	skinny_aead_cu #(
		.final_const (skinny_cu_pkg::final_const_default)
	) uut (
		.clk       (clk),
		.rst       (rst),
		.pdi_data  (pdi_data),
		.pdi_valid (pdi_valid),
		.last      (last),
		.pdo       (pdo),
		.pdi       (pdi),
		.pdi_ready (pdi_ready),
		.pdo_valid (pdo_valid),
		.ctrl      (ctrl),
		.domain    (domain),
		.fail      (fail)
	);

	always #50 clk = ~clk;

	task automatic report_failure();
		$display("Simulation FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_word(input string name, input skinny_cu_pkg::word_t exp,
			input skinny_cu_pkg::word_t act);
		if (exp !== act) begin
			$display("error %s expected %h actual %h", name, exp, act);
			report_failure();
		end
	endtask

	task automatic check_ctrl(input string name, input skinny_cu_pkg::cu_ctrl_t exp,
			input skinny_cu_pkg::cu_ctrl_t act);
		if (exp !== act) begin
			$display("error %s expected %b actual %b", name, exp, act);
			report_failure();
		end
	endtask

	task automatic check_domain(input string name, input skinny_cu_pkg::domain_t exp,
			input skinny_cu_pkg::domain_t act);
		if (exp !== act) begin
			$display("error %s expected %h actual %h", name, exp, act);
			report_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("error %s expected %b actual %b", name, exp, act);
			report_failure();
		end
	endtask

	// up to 400 cycles per transaction
	always @(posedge clk) begin
		cycles++;
		if (cycles >= 40 * 400) begin
			$display("timeout: the transactions did not finish within the cycle limit");
			report_failure();
		end
	end

	task automatic compare_outputs();
		string where;
		where = m_state.name();
		model_expect(pdi_valid, last, pdi_data, pdo);
		check_word({"pdi in ", where}, exp_pdi, pdi);
		check_ctrl({"ctrl in ", where}, exp_ctrl, ctrl);
		check_domain({"domain in ", where}, m_domain, domain);
		check_bit({"pdi_ready in ", where}, exp_ready, pdi_ready);
		check_bit({"pdo_valid in ", where}, exp_pvalid, pdo_valid);
		check_bit({"fail in ", where}, exp_fail, fail);
	endtask

	task automatic drive_inputs();
		logic [31:0] r;
		logic [31:0] r2;
		skinny_cu_pkg::opcode_t op;
		r  = $urandom;
		r2 = $urandom;
		pdo       <= (r[0] || tag_zero) ? '0 : (r2 | 32'h1);
		pdi_data  <= $urandom;
		last      <= r[1];
		pdi_valid <= (r[3:2] != 2'd0); // gaps one time in four
		if (m_state == skinny_cu_pkg::st_idle) begin
			if (issued < 40 && r[5:4] != 2'd0) begin
				op = (r[7:6] == 2'd0) ? skinny_cu_pkg::op_ldkey :
					(r[6] ? skinny_cu_pkg::op_dec : skinny_cu_pkg::op_enc);
				pdi_data  <= {op, r2[27:0]}; // lengths in the low byte
				pdi_valid <= 1'b1;
				ad_left  = {30'd0, r[9:8]};
				msg_left = {30'd0, r[11:10]};
				tag_zero = r[12];
				issued++;
			end else begin
				pdi_valid <= 1'b0;
			end
		end else if (m_rc == skinny_cu_pkg::final_const_default) begin
			if (m_state == skinny_cu_pkg::st_encrypt_ad) begin
				pdi_valid <= (ad_left != 0);
				if (ad_left != 0) ad_left--;
			end else if (m_state == skinny_cu_pkg::st_encrypt_msg) begin
				pdi_valid <= (msg_left != 0);
				if (msg_left != 0) msg_left--;
			end
		end
	endtask

	initial begin
		clk       = 1'b0;
		rst       = 1'b1;
		pdi_data  = '0;
		pdi_valid = 1'b0;
		last      = 1'b0;
		pdo       = '0;
		issued    = 0;
		cycles    = 0;
		ad_left   = 0;
		msg_left  = 0;
		tag_zero  = 1'b0;
		running   = 1'b1;
		void'($urandom(32'h303c2ca5));
		model_reset();
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		while (running) begin
			@(negedge clk);
			compare_outputs();
			if (issued == 40 && m_state == skinny_cu_pkg::st_idle && !pdi_valid) begin
				running = 1'b0;
			end else begin
				@(posedge clk);
				model_advance(pdi_valid, last, pdi_data, pdo);
				drive_inputs();
			end
		end
		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* logic/skinny_aead_cu.sv */
`timescale 1ns/1ps

module skinny_aead_cu #(
	parameter skinny_cu_pkg::rc_t final_const = skinny_cu_pkg::final_const_default
) (
	input  logic                     clk,
	input  logic                     rst,
	input  skinny_cu_pkg::word_t     pdi_data,
	input  logic                     pdi_valid,
	input  logic                     last,
	input  skinny_cu_pkg::word_t     pdo,
	output skinny_cu_pkg::word_t     pdi,
	output logic                     pdi_ready,
	output logic                     pdo_valid,
	output skinny_cu_pkg::cu_ctrl_t  ctrl,
	output skinny_cu_pkg::domain_t   domain,
	output logic                     fail
);

	skinny_cu_pkg::opcode_t pdi_opcode;
	skinny_cu_pkg::beat_t   beat;
	logic                   round_en;
	logic                   rc_restart;
	logic                   round_done;
	logic                   len_load;
	logic                   phase_ad;
	logic                   block_end;
	logic                   force_zero;
	logic                   verify;
	logic                   verify_last;
	logic                   dec;

	assign pdi_opcode = skinny_cu_pkg::opcode_t'(pdi_data[31:28]); // command field

	aead_sequencer u_sequencer (
		.clk         (clk),
		.rst         (rst),
		.pdi_opcode  (pdi_opcode),
		.pdi_valid   (pdi_valid),
		.last        (last),
		.round_done  (round_done),
		.ctrl        (ctrl),
		.pdi_ready   (pdi_ready),
		.pdo_valid   (pdo_valid),
		.round_en    (round_en),
		.rc_restart  (rc_restart),
		.len_load    (len_load),
		.phase_ad    (phase_ad),
		.beat        (beat),
		.block_end   (block_end),
		.force_zero  (force_zero),
		.verify      (verify),
		.verify_last (verify_last),
		.dec         (dec)
	);

	round_constant_lfsr #(
		.final_const (final_const)
	) u_lfsr (
		.clk        (clk),
		.rst        (rst),
		.rc_restart (rc_restart),
		.round_en   (round_en),
		.round_done (round_done)
	);

	block_formatter u_formatter (
		.clk        (clk),
		.rst        (rst),
		.pdi_data   (pdi_data),
		.pdi_valid  (pdi_valid),
		.last       (last),
		.len_load   (len_load),
		.phase_ad   (phase_ad),
		.block_end  (block_end),
		.force_zero (force_zero),
		.beat       (beat),
		.pdi        (pdi),
		.domain     (domain)
	);

	tag_checker u_tag_checker (
		.clk         (clk),
		.rst         (rst),
		.pdo         (pdo),
		.verify      (verify),
		.verify_last (verify_last),
		.dec         (dec),
		.fail        (fail)
	);

endmodule

/* logic/aead_sequencer.sv */
`timescale 1ns/1ps

module aead_sequencer (
	input  logic                     clk,
	input  logic                     rst,
	input  skinny_cu_pkg::opcode_t   pdi_opcode,
	input  logic                     pdi_valid,
	input  logic                     last,
	input  logic                     round_done,
	output skinny_cu_pkg::cu_ctrl_t  ctrl,
	output logic                     pdi_ready,
	output logic                     pdo_valid,
	output logic                     round_en,
	output logic                     rc_restart,
	output logic                     len_load,
	output logic                     phase_ad,
	output skinny_cu_pkg::beat_t     beat,
	output logic                     block_end,
	output logic                     force_zero,
	output logic                     verify,
	output logic                     verify_last,
	output logic                     dec
);

	skinny_cu_pkg::cu_state_t state;
	skinny_cu_pkg::cu_state_t state_next;
	logic                     dec_next;
	logic                     beat_step;
	logic                     store_state;
	logic                     last_beat;

	assign last_beat = (beat == 2'd3);

	assign store_state = (state == skinny_cu_pkg::st_store_key)
		|| (state == skinny_cu_pkg::st_store_nonce)
		|| (state == skinny_cu_pkg::st_store_l)
		|| (state == skinny_cu_pkg::st_store_ad)
		|| (state == skinny_cu_pkg::st_store_msg);

	// four-word states share one counter
	assign beat_step = store_state
		|| (state == skinny_cu_pkg::st_output_tag)
		|| (state == skinny_cu_pkg::st_verify_tag);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= skinny_cu_pkg::st_idle;
			beat  <= '0;
			dec   <= 1'b0;
		end else begin
			state <= state_next;
			beat  <= beat_step ? beat + 2'd1 : 2'd0; // wraps after the 4th word
			dec   <= dec_next;
		end
	end

	always_comb begin
		state_next  = state;
		dec_next    = dec;
		ctrl        = '0;
		pdi_ready   = 1'b0;
		pdo_valid   = 1'b0;
		round_en    = 1'b0;
		rc_restart  = 1'b0;
		len_load    = 1'b0;
		block_end   = 1'b0;
		force_zero  = 1'b0;
		verify      = 1'b0;
		verify_last = 1'b0;
		phase_ad    = (state == skinny_cu_pkg::st_store_ad)
			|| (state == skinny_cu_pkg::st_encrypt_ad);
		unique case (state)
			skinny_cu_pkg::st_idle: begin
				pdi_ready = 1'b1;
				ctrl.srst = 1'b1;
				ctrl.senc = 1'b1;
				ctrl.sse  = 1'b1;
				len_load  = 1'b1;
				if (pdi_valid) begin
					case (pdi_opcode)
						skinny_cu_pkg::op_ldkey: state_next = skinny_cu_pkg::st_store_key;
						skinny_cu_pkg::op_enc: begin
							state_next = skinny_cu_pkg::st_store_nonce;
							dec_next   = 1'b0;
						end
						skinny_cu_pkg::op_dec: begin
							state_next = skinny_cu_pkg::st_store_nonce;
							dec_next   = 1'b1;
						end
						skinny_cu_pkg::op_actkey: state_next = skinny_cu_pkg::st_idle; // no-op
						default: state_next = skinny_cu_pkg::st_idle;
					endcase
				end
			end
			skinny_cu_pkg::st_store_key: begin
				ctrl.xrst = 1'b1;
				ctrl.xenc = 1'b1;
				ctrl.xse  = 1'b1;
				if (last_beat) begin
					state_next = skinny_cu_pkg::st_idle;
				end
			end
			skinny_cu_pkg::st_store_nonce: begin
				pdi_ready  = 1'b1;
				ctrl.senc  = 1'b1;
				ctrl.sse   = 1'b1;
				rc_restart = last_beat;
				if (last_beat) begin
					state_next = skinny_cu_pkg::st_encrypt_nonce;
				end
			end
			skinny_cu_pkg::st_encrypt_nonce: begin
				ctrl.senc = 1'b1;
				ctrl.xenc = 1'b1;
				round_en  = 1'b1;
				if (round_done) begin
					pdi_ready  = 1'b1;
					state_next = skinny_cu_pkg::st_store_l;
				end
			end
			skinny_cu_pkg::st_store_l: begin
				force_zero  = 1'b1;
				ctrl.load_l = 1'b1;
				ctrl.xrst   = 1'b1;
				ctrl.xenc   = 1'b1;
				ctrl.xse    = 1'b1;
				ctrl.senc   = 1'b1;
				ctrl.sse    = 1'b1;
				ctrl.srst   = last_beat; // clear state before the first AD block
				if (last_beat) begin
					state_next = skinny_cu_pkg::st_store_ad;
				end
			end
			skinny_cu_pkg::st_store_ad, skinny_cu_pkg::st_store_msg: begin
				pdi_ready    = pdi_valid;
				ctrl.senc    = 1'b1;
				ctrl.sse     = 1'b1;
				if (state == skinny_cu_pkg::st_store_msg) begin
					pdo_valid    = pdi_valid;
					ctrl.decrypt = dec;
				end
				if (last_beat) begin
					block_end  = 1'b1;
					rc_restart = 1'b1;
					ctrl.xenc  = 1'b1;
					ctrl.xse   = 1'b1;
					state_next = (state == skinny_cu_pkg::st_store_ad) ?
						skinny_cu_pkg::st_encrypt_ad : skinny_cu_pkg::st_encrypt_msg;
				end
			end
			skinny_cu_pkg::st_encrypt_ad: begin
				ctrl.senc = 1'b1;
				ctrl.xenc = 1'b1;
				round_en  = 1'b1;
				if (round_done) begin
					if (pdi_valid) begin
						state_next = skinny_cu_pkg::st_store_ad;
					end else begin
						pdi_ready  = 1'b1;
						state_next = skinny_cu_pkg::st_store_msg;
					end
				end
			end
			skinny_cu_pkg::st_encrypt_msg: begin
				ctrl.senc = 1'b1;
				ctrl.xenc = 1'b1;
				round_en  = 1'b1;
				if (round_done) begin
					if (pdi_valid) begin
						state_next = skinny_cu_pkg::st_store_msg;
					end else if (dec) begin
						state_next = skinny_cu_pkg::st_verify_tag;
					end else begin
						state_next = skinny_cu_pkg::st_output_tag;
					end
				end
			end
			skinny_cu_pkg::st_output_tag: begin
				force_zero = 1'b1;
				pdo_valid  = 1'b1;
				ctrl.senc  = 1'b1;
				ctrl.sse   = 1'b1;
				if (last_beat) begin
					state_next = skinny_cu_pkg::st_idle;
				end
			end
			skinny_cu_pkg::st_verify_tag: begin
				verify      = 1'b1;
				verify_last = (beat == 2'd2);
				pdo_valid   = last_beat; // together with fail
				if (last_beat) begin
					state_next = skinny_cu_pkg::st_idle;
				end
			end
			default: state_next = skinny_cu_pkg::st_idle;
		endcase
	end

	// every four-word phase starts on the first word
	assert property (@(posedge clk) disable iff (rst)
		($changed(state) && store_state) |-> (beat == 2'd0));

endmodule

/* logic/tag_checker.sv */
`timescale 1ns/1ps

module tag_checker (
	input  logic                 clk,
	input  logic                 rst,
	input  skinny_cu_pkg::word_t pdo,
	input  logic                 verify,
	input  logic                 verify_last, // one beat before the final word
	input  logic                 dec,
	output logic                 fail
);

	logic pdo_zero;
	logic all_zero;
	logic last_q;

	assign pdo_zero = (pdo == '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			all_zero <= 1'b1;
			last_q   <= 1'b0;
		end else begin
			last_q   <= verify_last;
			all_zero <= verify ? (all_zero && pdo_zero) : 1'b1; // rearm between tags
		end
	end

	// final word joins the three accumulated ones
	assign fail = last_q && !(all_zero && pdo_zero && dec);

	// the sequencer only marks the end of a tag inside the verify window
	assert property (@(posedge clk) disable iff (rst)
		verify_last |-> verify);

endmodule

/* logic/block_formatter.sv */
`timescale 1ns/1ps

module block_formatter (
	input  logic                    clk,
	input  logic                    rst,
	input  skinny_cu_pkg::word_t    pdi_data,
	input  logic                    pdi_valid,
	input  logic                    last,
	input  logic                    len_load, // high while idle
	input  logic                    phase_ad,
	input  logic                    block_end,
	input  logic                    force_zero,
	input  skinny_cu_pkg::beat_t    beat,
	output skinny_cu_pkg::word_t    pdi,
	output skinny_cu_pkg::domain_t  domain
);

	skinny_cu_pkg::len_t    ad_len;
	skinny_cu_pkg::len_t    msg_len;
	skinny_cu_pkg::len_t    cur_len;
	skinny_cu_pkg::domain_t dom_normal;
	skinny_cu_pkg::domain_t dom_final;
	skinny_cu_pkg::domain_t dom_padded;
	skinny_cu_pkg::domain_t dom_next;
	logic                   tail_beat;

	assign tail_beat = block_end && (beat == 2'd3);
	assign cur_len = phase_ad ? ad_len : msg_len;

	assign dom_normal = phase_ad ? skinny_cu_pkg::dom_ad_normal : skinny_cu_pkg::dom_msg_normal;
	assign dom_final  = phase_ad ? skinny_cu_pkg::dom_ad_final : skinny_cu_pkg::dom_msg_final;
	assign dom_padded = phase_ad ? skinny_cu_pkg::dom_ad_padded : skinny_cu_pkg::dom_msg_padded;

	// lengths come with the command word
	always_ff @(posedge clk) begin
		if (len_load && pdi_valid) begin
			msg_len <= pdi_data[3:0];
			ad_len  <= pdi_data[7:4];
		end
	end

	always_comb begin
		pdi      = pdi_valid ? pdi_data : '0; // missing word reads as zero
		dom_next = dom_padded;
		if (tail_beat) begin
			if (pdi_valid && last) begin
				if (cur_len == '0) begin
					dom_next = dom_final; // full last block
				end else begin
					pdi = {pdi_data[31:4], cur_len}; // length in the pad nibble
				end
			end else if (pdi_valid) begin
				dom_next = dom_normal;
			end else begin
				pdi = {28'd0, cur_len}; // empty block, padding only
			end
		end
		if (force_zero) begin
			pdi = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || len_load) begin
			domain <= '0;
		end else if (tail_beat) begin
			domain <= dom_next;
		end
	end

endmodule

/* logic/round_constant_lfsr.sv */
`timescale 1ns/1ps

module round_constant_lfsr #(
	parameter skinny_cu_pkg::rc_t final_const = skinny_cu_pkg::final_const_default
) (
	input  logic clk,
	input  logic rst,
	input  logic rc_restart,
	input  logic round_en,
	output logic round_done
);

	skinny_cu_pkg::rc_t rc;

	always_ff @(posedge clk) begin
		if (rst || rc_restart) begin
			rc <= '0;
		end else if (round_en) begin
			rc <= {rc[4:0], ~(rc[5] ^ rc[4])}; // xnor of the top two bits
		end
	end

	assign round_done = (rc == final_const);

	// a round phase never starts in the cycle that rearms the constant
	assert property (@(posedge clk) disable iff (rst)
		!(round_en && rc_restart));

endmodule

/* logic/skinny_cu_pkg.sv */
package skinny_cu_pkg;

	typedef logic [31:0] word_t; // one bus word
	typedef logic [3:0]  len_t; // bytes in a partial last block
	typedef logic [7:0]  domain_t; // domain separation byte
	typedef logic [5:0]  rc_t; // round constant
	typedef logic [1:0]  beat_t; // word index within a block

	// command field, bits 31:28 of the command word
	typedef enum logic [3:0] {
		op_enc    = 4'd2,
		op_dec    = 4'd3,
		op_ldkey  = 4'd4,
		op_actkey = 4'd7
	} opcode_t;

	typedef enum logic [3:0] {
		st_idle,
		st_store_key,
		st_store_nonce,
		st_encrypt_nonce,
		st_store_l,
		st_store_ad,
		st_encrypt_ad,
		st_store_msg,
		st_encrypt_msg,
		st_output_tag,
		st_verify_tag
	} cu_state_t;

	typedef struct packed {
		logic srst; // state register
		logic senc;
		logic sse;
		logic xrst; // tweakey register
		logic xenc;
		logic xse;
		logic load_l;
		logic decrypt;
	} cu_ctrl_t;

	localparam domain_t dom_ad_normal  = 8'd4;
	localparam domain_t dom_ad_final   = 8'd12;
	localparam domain_t dom_ad_padded  = 8'd13;
	localparam domain_t dom_msg_normal = 8'd2;
	localparam domain_t dom_msg_final  = 8'd10;
	localparam domain_t dom_msg_padded = 8'd11;

	// constant of the last SKINNY round
	localparam rc_t final_const_default = 6'b011010;

endpackage
